//--- design/rv64_pkg.sv
`default_nettype none

package rv64_pkg;

  // wishbone classic master to slave bundle.
  typedef struct packed {
    logic        cyc;  // bus cycle in progress.
    logic        stb;  // strobe, one access.
    logic        we;   // write when high.
    logic [5:0]  adr;  // word address.
    logic [63:0] dat;  // write data.
  } wb_m2s_t;

  // wishbone classic slave to master bundle.
  typedef struct packed {
    logic        ack;  // one cycle per access.
    logic [63:0] dat;  // read data, valid with ack.
  } wb_s2m_t;

  // one instruction handed from the bus to the decoder.
  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
  } inst_req_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_imm  // lui puts the u-type immediate straight through.
  } alu_op_e;

  typedef struct packed {
    logic        valid;     // an instruction is issued this cycle.
    logic        legal;     // opcode and funct fields are supported.
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  rd_addr;
    logic        rs1_en;
    logic        rs2_en;
    logic        rd_we;
    logic        use_imm;   // second operand is imm, not rs2.
    logic [63:0] imm;       // sign-extended immediate.
    alu_op_e     alu_op;
  } dec_op_t;

  typedef struct packed {
    logic        en;
    logic [4:0]  addr;
    logic [63:0] data;
  } rf_wr_t;

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  // funct3 codes shared by op and op-imm.
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  localparam logic [5:0] adr_instr  = 6'd0;   // writes here execute.
  localparam logic [5:0] adr_status = 6'd32;  // {illegal, retired}.

  localparam logic [63:0] regs_init = 64'd0;

endpackage

`default_nettype wire

//--- design/rv64_wb_slave.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_wb_slave (
  input  wire                 clk,
  input  wire                 rst,
  input  rv64_pkg::wb_m2s_t   bus_in,
  output rv64_pkg::wb_s2m_t   bus_out,
  output rv64_pkg::inst_req_t issue,
  output logic [5:0]          rd_adr,
  input  wire [63:0]          rd_data
);
  import rv64_pkg::*;

  logic        ack_q;       // ack for the access sampled last edge.
  logic [63:0] dat_q;       // read data held with ack.
  logic        new_access;  // first cycle of an access.
  logic        issue_valid;

  // an access is new while the strobe is up and no ack has gone out yet.
  assign new_access = bus_in.cyc && bus_in.stb && !ack_q;

  // only a write to the instruction word executes.
  assign issue_valid = new_access && bus_in.we && (bus_in.adr == adr_instr);

  assign issue = '{
    valid: issue_valid,
    instr: bus_in.dat[31:0]  // upper half of the bus word is unused.
  };

  assign rd_adr = bus_in.adr;  // read select goes out unregistered.

  // one cycle from strobe to ack, no wait states.
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= new_access;  // drops after one cycle since new_access needs !ack_q.
    end
  end

  // capture read data on the same edge that raises ack.
  always_ff @(posedge clk) begin
    if (new_access && !bus_in.we) begin
      dat_q <= rd_data;
    end
  end

  assign bus_out = '{
    ack: ack_q,
    dat: dat_q
  };

endmodule

`default_nettype wire

//--- design/rv64_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_decoder (
  input  rv64_pkg::inst_req_t issue,
  output rv64_pkg::dec_op_t   dec
);
  import rv64_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic        op_f7_ok;   // funct7 valid for the op group.
  logic        imm_sh_ok;  // shift encoding valid for op-imm.
  logic        legal;
  alu_op_e     f3_op;      // base operation from funct3.

  assign opcode = issue.instr[6:0];
  assign funct3 = issue.instr[14:12];
  assign funct7 = issue.instr[31:25];

  assign imm_i = {{52{issue.instr[31]}}, issue.instr[31:20]};
  assign imm_u = {{32{issue.instr[31]}}, issue.instr[31:12], 12'b0};

  // sub and sra are the only op forms with bit 30 set.
  assign op_f7_ok = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) && ((funct3 == f3_add) || (funct3 == f3_srl)));

  // rv64 shifts carry a 6-bit shamt, so only instr[31:26] is checked.
  always_comb begin
    imm_sh_ok = 1'b1;
    if (funct3 == f3_sll) begin
      imm_sh_ok = (issue.instr[31:26] == 6'b000000);
    end else if (funct3 == f3_srl) begin
      imm_sh_ok = (issue.instr[31:26] == 6'b000000) || (issue.instr[31:26] == 6'b010000);
    end
  end

  // funct3 to alu op, bit 30 picks sub or sra.
  always_comb begin
    case (funct3)
      f3_add:  f3_op = (issue.instr[30] && opcode == opc_op) ? alu_sub : alu_add;
      f3_sll:  f3_op = alu_sll;
      f3_slt:  f3_op = alu_slt;
      f3_sltu: f3_op = alu_sltu;
      f3_xor:  f3_op = alu_xor;
      f3_srl:  f3_op = issue.instr[30] ? alu_sra : alu_srl;
      f3_or:   f3_op = alu_or;
      default: f3_op = alu_and;
    endcase
  end

  always_comb begin
    case (opcode)
      opc_op:     legal = op_f7_ok;
      opc_op_imm: legal = imm_sh_ok;
      opc_lui:    legal = 1'b1;
      default:    legal = 1'b0;
    endcase
  end

  always_comb begin
    dec          = '0;
    dec.valid    = issue.valid;
    dec.legal    = legal;
    dec.rs1_addr = issue.instr[19:15];
    dec.rs2_addr = issue.instr[24:20];
    dec.rd_addr  = issue.instr[11:7];
    dec.rd_we    = legal;              // every supported instruction writes rd.
    dec.rs1_en   = legal && (opcode != opc_lui);
    dec.rs2_en   = legal && (opcode == opc_op);  // rs2 is read by op only.
    dec.use_imm  = (opcode != opc_op);
    dec.imm      = (opcode == opc_lui) ? imm_u : imm_i;
    dec.alu_op   = (opcode == opc_lui) ? alu_pass_imm : f3_op;
  end

endmodule

`default_nettype wire

//--- design/rv64_reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_reg_file (
  input  wire              clk,
  input  wire              rst,
  input  wire              rs1_en,
  input  wire [4:0]        rs1_addr,
  input  wire              rs2_en,
  input  wire [4:0]        rs2_addr,
  output logic [63:0]      rs1_data,
  output logic [63:0]      rs2_data,
  input  wire [4:0]        dbg_addr,
  output logic [63:0]      dbg_data,
  input  rv64_pkg::rf_wr_t wr
);
  import rv64_pkg::*;

  logic [63:0] regs [0:31];
  logic        wr_en;  // write enable with x0 masked.

  // operand ports, a disabled port reads the reset value.
  assign rs1_data = rs1_en ? regs[rs1_addr] : regs_init;
  assign rs2_data = rs2_en ? regs[rs2_addr] : regs_init;

  assign dbg_data = regs[dbg_addr];  // host view for bus reads.

  assign wr_en = wr.en && (wr.addr != 5'd0);  // x0 is never written.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= regs_init;
      end
    end else if (wr_en) begin
      regs[wr.addr] <= wr.data;
    end
  end

endmodule

`default_nettype wire

//--- design/rv64_alu.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_alu (
  input  rv64_pkg::dec_op_t dec,
  input  wire [63:0]        rs1_data,
  input  wire [63:0]        rs2_data,
  output logic [63:0]       result
);
  import rv64_pkg::*;

  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [5:0]  shamt;     // rv64 shifts use the low 6 bits.
  logic        lt_s;      // signed less-than.
  logic        lt_u;      // unsigned less-than.
  logic [63:0] sum;
  logic [63:0] diff;

  assign op_a  = rs1_data;
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[5:0];

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  always_comb begin
    case (dec.alu_op)
      alu_add:      result = sum;
      alu_sub:      result = diff;
      alu_sll:      result = op_a << shamt;
      alu_slt:      result = {63'd0, lt_s};
      alu_sltu:     result = {63'd0, lt_u};
      alu_xor:      result = op_a ^ op_b;
      alu_srl:      result = op_a >> shamt;
      alu_sra:      result = $unsigned($signed(op_a) >>> shamt);  // sign fill.
      alu_or:       result = op_a | op_b;
      alu_and:      result = op_a & op_b;
      alu_pass_imm: result = dec.imm;  // lui.
      default:      result = 64'd0;
    endcase
  end

endmodule

`default_nettype wire

//--- design/rv64_retire_unit.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_retire_unit (
  input  wire               clk,
  input  wire               rst,
  input  rv64_pkg::dec_op_t dec,
  input  wire [63:0]        result,
  output rv64_pkg::rf_wr_t  wr,
  input  wire [5:0]         rd_adr,
  input  wire [63:0]        dbg_data,
  output logic [63:0]       rd_data
);
  import rv64_pkg::*;

  logic [31:0] retired_cnt;  // legal instructions executed.
  logic [31:0] illegal_cnt;  // unsupported encodings seen.
  logic        wr_en;

  // x0 writes are dropped here as well as in the register file.
  assign wr_en = dec.valid && dec.legal && dec.rd_we && (dec.rd_addr != 5'd0);

  assign wr = '{
    en:   wr_en,
    addr: dec.rd_addr,
    data: result
  };

  // counters wrap at 2**32.
  always_ff @(posedge clk) begin
    if (rst) begin
      retired_cnt <= 32'd0;
      illegal_cnt <= 32'd0;
    end else if (dec.valid) begin
      if (dec.legal) begin
        retired_cnt <= retired_cnt + 32'd1;
      end else begin
        illegal_cnt <= illegal_cnt + 32'd1;
      end
    end
  end

  // status word sits above the register window.
  assign rd_data = (rd_adr == adr_status) ? {illegal_cnt, retired_cnt} : dbg_data;

endmodule

`default_nettype wire

//--- design/rv64_exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv64_exec_top (
  input  wire               clk,
  input  wire               rst,
  input  rv64_pkg::wb_m2s_t bus_in,
  output rv64_pkg::wb_s2m_t bus_out
);
  import rv64_pkg::*;

  inst_req_t   issue;
  dec_op_t     dec;
  rf_wr_t      wr;
  logic [5:0]  rd_adr;
  logic [63:0] rd_data;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  logic [63:0] dbg_data;
  logic [63:0] result;

  rv64_wb_slave rv64_wb_slave_inst (
    .clk     (clk),
    .rst     (rst),
    .bus_in  (bus_in),
    .bus_out (bus_out),
    .issue   (issue),
    .rd_adr  (rd_adr),
    .rd_data (rd_data)
  );

  rv64_decoder rv64_decoder_inst (
    .issue (issue),
    .dec   (dec)
  );

  rv64_reg_file rv64_reg_file_inst (
    .clk      (clk),
    .rst      (rst),
    .rs1_en   (dec.rs1_en),
    .rs1_addr (dec.rs1_addr),
    .rs2_en   (dec.rs2_en),
    .rs2_addr (dec.rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dbg_addr (rd_adr[4:0]),  // low bits index x0 to x31.
    .dbg_data (dbg_data),
    .wr       (wr)
  );

  rv64_alu rv64_alu_inst (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (result)
  );

  rv64_retire_unit rv64_retire_unit_inst (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .result   (result),
    .wr       (wr),
    .rd_adr   (rd_adr),
    .dbg_data (dbg_data),
    .rd_data  (rd_data)
  );

endmodule

`default_nettype wire

//--- tb/rv64_ref_model.svh
// reference model of the rv64i subset, kept in the testbench scope.
logic [63:0] model_regs [0:31];  // x0 is never written so it stays zero.
logic [31:0] model_retired;      // legal instructions executed.
logic [31:0] model_illegal;      // rejected encodings.

function automatic void model_reset();
  for (int i = 0; i < 32; i++) begin
    model_regs[i[4:0]] = 64'd0;
  end
  model_retired = 32'd0;
  model_illegal = 32'd0;
endfunction

// executes one instruction word as the isa defines it.
function automatic void model_execute(input logic [31:0] instr);
  logic [6:0]  opcode;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [4:0]  rd;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] res;
  logic [5:0]  sh;
  logic        is_op;
  logic        legal;
  opcode = instr[6:0];
  f3     = instr[14:12];
  f7     = instr[31:25];
  rd     = instr[11:7];
  is_op  = (opcode == 7'b0110011);
  a      = model_regs[instr[19:15]];
  b      = is_op ? model_regs[instr[24:20]] : {{52{instr[31]}}, instr[31:20]};  // i-type imm.
  sh     = b[5:0];   // six shift bits on rv64.
  res    = 64'd0;
  legal  = 1'b0;
  if (opcode == 7'b0110111) begin
    legal = 1'b1;
    res   = {{32{instr[31]}}, instr[31:12], 12'h000};  // lui sign-extends bit 31.
  end else if (is_op || (opcode == 7'b0010011)) begin
    if (is_op) begin
      legal = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
    end else begin
      case (f3)
        3'd1:    legal = (instr[31:26] == 6'h00);
        3'd5:    legal = (instr[31:26] == 6'h00) || (instr[31:26] == 6'h10);
        default: legal = 1'b1;  // plain immediates take any value.
      endcase
    end
    case (f3)
      3'd0:    res = (is_op && instr[30]) ? a - b : a + b;
      3'd1:    res = a << sh;
      3'd2:    res = {63'd0, $signed(a) < $signed(b)};
      3'd3:    res = {63'd0, a < b};
      3'd4:    res = a ^ b;
      3'd5:    res = instr[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
      3'd6:    res = a | b;
      default: res = a & b;
    endcase
  end
  if (legal) begin
    model_retired = model_retired + 32'd1;
    if (rd != 5'd0) begin
      model_regs[rd] = res;
    end
  end else begin
    model_illegal = model_illegal + 32'd1;  // no register changes.
  end
endfunction

//--- tb/tb_rv64_exec.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv64_exec;
  import rv64_pkg::*;

  localparam int access_budget  = 760;  // about 734 bus accesses over all tests.
  localparam int timeout_cycles = access_budget * 3 * 2 + 8;

  logic        clk;
  logic        rst;
  wb_m2s_t     bus_in;
  wb_s2m_t     bus_out;
  integer      seed;
  int          errors;
  int          errors_at_start;  // errors before the running test.
  int          checks;
  int          test_count;
  int          cycle_count = 0;
  logic [63:0] rd_val;
  logic [31:0] instr;
  logic [4:0]  prev_rd;          // dependency chain in test 6.

  `include "rv64_ref_model.svh"

  rv64_exec_top rv64_exec_top_inst (
    .clk     (clk),
    .rst     (rst),
    .bus_in  (bus_in),
    .bus_out (bus_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period.
  end

  // a hung handshake ends the run here.
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: no bus ack after %0d cycles, run stopped", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = rand32();
    return r[4:0];
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opc_lui};
  endfunction

  // random op form, funct7 0x20 only where sub and sra exist.
  function automatic logic [31:0] random_op(input logic [4:0] rs1);
    logic [31:0] r;
    logic [6:0]  f7;
    r  = rand32();
    f7 = 7'h00;
    if (r[3] && ((r[2:0] == 3'd0) || (r[2:0] == 3'd5))) begin
      f7 = 7'h20;
    end
    return encode_r(f7, r[8:4], rs1, r[2:0], r[13:9]);
  endfunction

  // op-imm or lui, biased toward immediate and shamt corners.
  function automatic logic [31:0] random_imm(input logic [4:0] rs1);
    logic [31:0] r;
    logic [31:0] s;
    logic [11:0] imm;
    logic [5:0]  shamt;
    r     = rand32();
    s     = rand32();
    imm   = r[19:8];
    shamt = r[27:22];
    case (r[30:28])
      3'd0:    imm = 12'h800;  // most negative immediate.
      3'd1:    imm = 12'hfff;  // minus one.
      default: imm = r[19:8];
    endcase
    case (s[1:0])
      2'd0:    shamt = 6'd0;
      2'd1:    shamt = 6'd63;
      default: shamt = r[27:22];
    endcase
    if (r[2:0] == 3'd1) begin
      imm = {6'b000000, shamt};
    end else if (r[2:0] == 3'd5) begin
      imm = {r[31] ? 6'b010000 : 6'b000000, shamt};  // srai or srli.
    end
    if (s[4:2] == 3'd0) begin
      return encode_u(s[31:12], r[7:3]);
    end
    return encode_i(imm, rs1, r[2:0], r[7:3]);
  endfunction

  function automatic logic [31:0] random_illegal();
    logic [31:0] r;
    logic [31:0] w;
    r = rand32();
    w = r;
    case (r[1:0])
      2'd0: w = {7'b0000001, r[24:7], opc_op};                    // m extension funct7.
      2'd1: w = encode_i({6'b100000, r[7:2]}, r[12:8], 3'd1, r[17:13]);  // bad slli.
      2'd2: w = encode_i({6'b110000, r[7:2]}, r[12:8], 3'd5, r[17:13]);  // bad srai.
      default: begin
        if ((r[6:0] == opc_op) || (r[6:0] == opc_op_imm) || (r[6:0] == opc_lui)) begin
          w[6] = 1'b1;  // moves it to an unsupported opcode.
        end
      end
    endcase
    return w;
  endfunction

  task automatic bus_write(input logic [5:0] adr, input logic [63:0] dat);
    @(negedge clk);
    bus_in.cyc = 1'b1;
    bus_in.stb = 1'b1;
    bus_in.we  = 1'b1;
    bus_in.adr = adr;
    bus_in.dat = dat;
    @(negedge clk);
    while (!bus_out.ack) begin
      @(negedge clk);
    end
    bus_in.cyc = 1'b0;
    bus_in.stb = 1'b0;
    bus_in.we  = 1'b0;
  endtask

  task automatic bus_read(input logic [5:0] adr, output logic [63:0] dat);
    @(negedge clk);
    bus_in.cyc = 1'b1;
    bus_in.stb = 1'b1;
    bus_in.we  = 1'b0;
    bus_in.adr = adr;
    @(negedge clk);
    while (!bus_out.ack) begin
      @(negedge clk);
    end
    dat        = bus_out.dat;  // held with ack.
    bus_in.cyc = 1'b0;
    bus_in.stb = 1'b0;
  endtask

  // upper bus half carries noise, only the low word is the instruction.
  task automatic exec_instr(input logic [31:0] word);
    logic [31:0] upper;
    upper = rand32();
    bus_write(adr_instr, {upper, word});
    model_execute(word);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_regs();
    logic [63:0] d;
    for (int i = 0; i < 32; i++) begin
      bus_read(i[5:0], d);
      check_value($sformatf("x%0d", i), d, model_regs[i[4:0]]);
    end
  endtask

  task automatic check_status();
    logic [63:0] d;
    bus_read(adr_status, d);
    check_value("status {illegal, retired}", d, {model_illegal, model_retired});
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %0d %s: %0d errors", test_count, name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  initial begin
    seed            = 32'hbcd19c93;
    errors          = 0;
    errors_at_start = 0;
    checks          = 0;
    test_count      = 0;
    rst             = 1'b1;
    bus_in          = '0;
    model_reset();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_regs();
    check_status();
    finish_test("reset state");

    for (int r = 1; r < 32; r++) begin
      instr = rand32();
      exec_instr(encode_i(instr[31:20], 5'd0, 3'd0, r[4:0]));  // addi xr, x0, imm.
    end
    for (int b = 0; b < 3; b++) begin
      for (int k = 0; k < 50; k++) begin
        exec_instr(random_op(rand_reg()));
      end
      check_regs();
    end
    finish_test("random op");

    for (int b = 0; b < 3; b++) begin
      for (int k = 0; k < 50; k++) begin
        exec_instr(random_imm(rand_reg()));
      end
      check_regs();
    end
    finish_test("random op-imm and lui");

    exec_instr(encode_i(12'h005, 5'd0, 3'd0, 5'd0));       // addi x0, x0, 5.
    exec_instr(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));   // add x0, x1, x2.
    exec_instr(encode_u(20'hfffff, 5'd0));                 // lui x0.
    bus_read(6'd0, rd_val);
    check_value("x0", rd_val, 64'd0);
    exec_instr(encode_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd5));   // add x5, x0, x0.
    exec_instr(encode_i(12'hfff, 5'd0, 3'd0, 5'd6));       // addi x6, x0, -1.
    exec_instr(encode_r(7'h20, 5'd3, 5'd0, 3'd0, 5'd7));   // sub x7, x0, x3.
    exec_instr(encode_r(7'h00, 5'd0, 5'd8, 3'd6, 5'd9));   // or x9, x8, x0.
    bus_write(6'd6, 64'd0);  // register window is read only.
    bus_read(6'd6, rd_val);
    check_value("x6", rd_val, 64'hffff_ffff_ffff_ffff);
    check_regs();
    finish_test("x0 handling");

    for (int k = 0; k < 30; k++) begin
      exec_instr(random_illegal());
    end
    check_regs();
    check_status();
    finish_test("illegal encodings");

    prev_rd = 5'd1;
    for (int k = 0; k < 40; k++) begin
      instr = rand32();
      instr = instr[0] ? random_op(prev_rd) : random_imm(prev_rd);
      if (instr[11:7] == 5'd0) begin
        instr[11:7] = 5'd1;  // keep the chain on a real register.
      end
      exec_instr(instr);
      prev_rd = instr[11:7];
    end
    check_regs();
    check_status();
    finish_test("dependent chain");

    $display("tests %0d, checks %0d, errors %0d", test_count, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tb
design/rv64_pkg.sv
design/rv64_wb_slave.sv
design/rv64_decoder.sv
design/rv64_reg_file.sv
design/rv64_alu.sv
design/rv64_retire_unit.sv
design/rv64_exec_top.sv
tb/tb_rv64_exec.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f vlog.f \
  --top-module tb_rv64_exec -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
echo "pass message not found"
exit 1
